//--- verilog/l2_miss_defines.svh
`ifndef L2_MISS_DEFINES_SVH
`define L2_MISS_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

`define L2M_ADDR_W       28     // word address of a miss request
`define L2M_LINE_ADDR_W  26     // memory works on whole lines
`define L2M_LINE_W       512
`define L2M_WORD_W       128    // one L1 refill word
`define L2M_WAYS         4
`define L2M_WAY_W        2
`define L2M_L2_TAG_W     18     // valid bit included
`define L2M_L1_TAG_W     21     // valid bit included
`define L2M_L1_INDEX_W   8

////////////////////////////////////////////////////////////////////////////
// request address fields
////////////////////////////////////////////////////////////////////////////

`define L2M_WSEL_HI      1      // word within the line
`define L2M_WSEL_LO      0
`define L2M_L1_IDX_HI    7
`define L2M_L1_IDX_LO    0
`define L2M_SET_HI       10     // L2 set, low half of a write-back address
`define L2M_SET_LO       2
`define L2M_L2_TAG_HI    27
`define L2M_L2_TAG_LO    11
`define L2M_L1_TAG_HI    27
`define L2M_L1_TAG_LO    8

`endif

//--- verilog/l2_miss_pkg.sv
`default_nettype none

package l2_miss_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // miss controller states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        IDLE       = 2'd0,  // waiting for a miss
        WRITE_BACK = 2'd1,  // dirty victim going out to memory
        READ_LINE  = 2'd2,  // new line coming in
        FILL       = 2'd3   // one cycle write into L2 and L1
    } miss_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // access that caused the miss
    ////////////////////////////////////////////////////////////////////////////

    // a read also refills L1, a write only refills L2
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_t;

endpackage

`default_nettype wire

//--- verilog/l2_victim_select.sv
`default_nettype none

`include "l2_miss_defines.svh"

module l2_victim_select (
    input  logic [`L2M_WAY_W-1:0]       req_way,        // captured victim way
    input  logic [`L2M_ADDR_W-1:0]      req_addr,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag0_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag1_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag2_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag3_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data0_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data1_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data2_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data3_rd,
    output logic [`L2M_LINE_W-1:0]      wb_line,
    output logic [`L2M_LINE_ADDR_W-1:0] wb_line_addr
);

    logic [`L2M_L2_TAG_W-1:0] tags  [`L2M_WAYS];
    logic [`L2M_LINE_W-1:0]   lines [`L2M_WAYS];
    logic [`L2M_L2_TAG_W-1:0] victim_tag;
    logic [`L2M_SET_HI-`L2M_SET_LO:0] req_set;

    ////////////////////////////////////////////////////////////////////////////
    // way arrays
    ////////////////////////////////////////////////////////////////////////////

    assign tags[0]  = l2_tag0_rd;
    assign tags[1]  = l2_tag1_rd;
    assign tags[2]  = l2_tag2_rd;
    assign tags[3]  = l2_tag3_rd;

    assign lines[0] = l2_data0_rd;
    assign lines[1] = l2_data1_rd;
    assign lines[2] = l2_data2_rd;
    assign lines[3] = l2_data3_rd;

    ////////////////////////////////////////////////////////////////////////////
    // victim pick
    ////////////////////////////////////////////////////////////////////////////

    assign victim_tag = tags[req_way];
    assign wb_line    = lines[req_way];     // line that goes back to memory

    // victim lives in the same set as the request
    assign req_set = req_addr[`L2M_SET_HI:`L2M_SET_LO];

    // old tag without its valid bit, then the set
    assign wb_line_addr = {
        victim_tag[`L2M_L2_TAG_W-2:0],
        req_set
    };

endmodule

`default_nettype wire

//--- verilog/l2_refill_route.sv
`default_nettype none

`include "l2_miss_defines.svh"

module l2_refill_route
    import l2_miss_pkg::*;
(
    input  logic                       fill,           // single FILL cycle
    input  logic [`L2M_ADDR_W-1:0]     req_addr,
    input  access_op_t                 req_op,
    input  logic [`L2M_WAY_W-1:0]      req_way,
    input  logic                       req_l1_way,
    input  logic                       req_l1_side,
    input  logic [`L2M_LINE_W-1:0]     fill_line_q,
    // L2 write port
    output logic [`L2M_WAYS-1:0]       l2_way_we,
    output logic [`L2M_L2_TAG_W-1:0]   l2_tag_wd,
    output logic [`L2M_LINE_W-1:0]     l2_fill_line,
    // L1 refill port
    output logic                       l1_fill_valid,
    output logic                       l1_fill_side,   // 0 icache, 1 dcache
    output logic [1:0]                 l1_block_we,
    output logic [`L2M_L1_TAG_W-1:0]   l1_tag_wd,
    output logic [`L2M_L1_INDEX_W-1:0] l1_index,
    output logic [`L2M_WORD_W-1:0]     l1_word
);

    logic [`L2M_WSEL_HI-`L2M_WSEL_LO:0] word_sel;

    ////////////////////////////////////////////////////////////////////////////
    // L2 side
    ////////////////////////////////////////////////////////////////////////////

    // one-hot way enable, only while filling
    assign l2_way_we = fill ? (`L2M_WAYS'(1) << req_way) : '0;

    assign l2_tag_wd    = {1'b1, req_addr[`L2M_L2_TAG_HI:`L2M_L2_TAG_LO]};
    assign l2_fill_line = fill_line_q;

    ////////////////////////////////////////////////////////////////////////////
    // L1 side
    ////////////////////////////////////////////////////////////////////////////

    // a write miss finishes in L2, L1 is left alone
    assign l1_fill_valid = fill && (req_op == OP_READ);
    assign l1_fill_side  = req_l1_side;

    always_comb begin
        l1_block_we = 2'b00;
        if (l1_fill_valid) begin
            if (req_l1_way) begin
                l1_block_we = 2'b10;
            end else begin
                l1_block_we = 2'b01;
            end
        end
    end

    assign l1_tag_wd = {1'b1, req_addr[`L2M_L1_TAG_HI:`L2M_L1_TAG_LO]};
    assign l1_index  = req_addr[`L2M_L1_IDX_HI:`L2M_L1_IDX_LO];

    // addressed word out of the new line
    assign word_sel = req_addr[`L2M_WSEL_HI:`L2M_WSEL_LO];

    always_comb begin
        case (word_sel)
            2'd0:    l1_word = fill_line_q[1*`L2M_WORD_W-1:0*`L2M_WORD_W];
            2'd1:    l1_word = fill_line_q[2*`L2M_WORD_W-1:1*`L2M_WORD_W];
            2'd2:    l1_word = fill_line_q[3*`L2M_WORD_W-1:2*`L2M_WORD_W];
            default: l1_word = fill_line_q[4*`L2M_WORD_W-1:3*`L2M_WORD_W];
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/l2_miss_fsm.sv
`default_nettype none

`include "l2_miss_defines.svh"

module l2_miss_fsm
    import l2_miss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    // miss request from L2
    input  logic                        miss_valid,
    input  logic                        miss_dirty,
    input  access_op_t                  miss_op,
    input  logic [`L2M_ADDR_W-1:0]      miss_addr,
    input  logic [`L2M_WAY_W-1:0]       victim_way,
    input  logic                        l1_way,
    input  logic                        l1_side,
    // victim from l2_victim_select
    input  logic [`L2M_LINE_ADDR_W-1:0] wb_line_addr,
    input  logic [`L2M_LINE_W-1:0]      wb_line,
    // memory answers
    input  logic                        mem_done_r,
    input  logic                        mem_done_w,
    input  logic [`L2M_LINE_W-1:0]      mem_rdata,
    output logic                        busy,
    output logic                        mem_re,
    output logic                        mem_we,
    output logic [`L2M_LINE_ADDR_W-1:0] mem_addr,
    output logic [`L2M_LINE_W-1:0]      mem_wdata,
    output logic                        fill,
    // captured request
    output logic [`L2M_ADDR_W-1:0]      req_addr,
    output access_op_t                  req_op,
    output logic [`L2M_WAY_W-1:0]       req_way,
    output logic                        req_l1_way,
    output logic                        req_l1_side,
    output logic [`L2M_LINE_W-1:0]      fill_line_q
);

    miss_state_t state;
    miss_state_t state_d;
    logic        accept;
    logic [`L2M_LINE_ADDR_W-1:0] req_line_addr;

    assign busy   = (state != IDLE);
    assign accept = miss_valid && !busy;  // misses seen while busy are dropped
    assign fill   = (state == FILL);

    ////////////////////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    // dirty victim must reach memory before the read
                    state_d = miss_dirty ? WRITE_BACK : READ_LINE;
                end
            end
            WRITE_BACK: begin
                if (mem_done_w) begin
                    state_d = READ_LINE;
                end
            end
            READ_LINE: begin
                if (mem_done_r) begin
                    state_d = FILL;
                end
            end
            FILL:    state_d = IDLE;    // single cycle
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory handshake
    ////////////////////////////////////////////////////////////////////////////

    // request held until its done pulse, then dropped or swapped next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_we <= 1'b0;
            mem_re <= 1'b0;
        end else begin
            mem_we <= (state_d == WRITE_BACK);
            mem_re <= (state_d == READ_LINE);
        end
    end

    assign req_line_addr = req_addr[`L2M_ADDR_W-1:`L2M_WSEL_HI+1];

    // victim address while writing back, own line otherwise
    assign mem_addr  = (state == WRITE_BACK) ? wb_line_addr : req_line_addr;
    assign mem_wdata = wb_line;     // stable, request fields don't move

    ////////////////////////////////////////////////////////////////////////////
    // request and line capture
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr    <= miss_addr;
            req_op      <= miss_op;
            req_way     <= victim_way;
            req_l1_way  <= l1_way;
            req_l1_side <= l1_side;
        end
    end

    // new line, written out during FILL
    always_ff @(posedge clk) begin
        if ((state == READ_LINE) && mem_done_r) begin
            fill_line_q <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/l2_miss_ctrl.sv
`default_nettype none

`include "l2_miss_defines.svh"

module l2_miss_ctrl
    import l2_miss_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    // L2 miss request
    input  logic                        miss_valid,
    input  logic                        miss_dirty,
    input  access_op_t                  miss_op,
    input  logic [`L2M_ADDR_W-1:0]      miss_addr,
    input  logic [`L2M_WAY_W-1:0]       victim_way,
    input  logic                        l1_way,
    input  logic                        l1_side,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag0_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag1_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag2_rd,
    input  logic [`L2M_L2_TAG_W-1:0]    l2_tag3_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data0_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data1_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data2_rd,
    input  logic [`L2M_LINE_W-1:0]      l2_data3_rd,
    output logic                        busy,
    // main memory
    output logic                        mem_re,
    output logic                        mem_we,
    output logic [`L2M_LINE_ADDR_W-1:0] mem_addr,
    output logic [`L2M_LINE_W-1:0]      mem_wdata,
    input  logic                        mem_done_r,
    input  logic                        mem_done_w,
    input  logic [`L2M_LINE_W-1:0]      mem_rdata,
    // L2 fill
    output logic [`L2M_WAYS-1:0]        l2_way_we,
    output logic [`L2M_LINE_W-1:0]      l2_fill_line,
    output logic [`L2M_L2_TAG_W-1:0]    l2_tag_wd,
    // L1 refill
    output logic                        l1_fill_valid,
    output logic                        l1_fill_side,
    output logic [1:0]                  l1_block_we,
    output logic [`L2M_L1_TAG_W-1:0]    l1_tag_wd,
    output logic [`L2M_L1_INDEX_W-1:0]  l1_index,
    output logic [`L2M_WORD_W-1:0]      l1_word
);

    logic [`L2M_LINE_W-1:0]      wb_line;
    logic [`L2M_LINE_ADDR_W-1:0] wb_line_addr;
    logic                        fill;
    logic [`L2M_ADDR_W-1:0]      req_addr;
    access_op_t                  req_op;
    logic [`L2M_WAY_W-1:0]       req_way;
    logic                        req_l1_way;
    logic                        req_l1_side;
    logic [`L2M_LINE_W-1:0]      fill_line_q;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    l2_miss_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .miss_valid   (miss_valid),
        .miss_dirty   (miss_dirty),
        .miss_op      (miss_op),
        .miss_addr    (miss_addr),
        .victim_way   (victim_way),
        .l1_way       (l1_way),
        .l1_side      (l1_side),
        .wb_line_addr (wb_line_addr),
        .wb_line      (wb_line),
        .mem_done_r   (mem_done_r),
        .mem_done_w   (mem_done_w),
        .mem_rdata    (mem_rdata),
        .busy         (busy),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .fill         (fill),
        .req_addr     (req_addr),
        .req_op       (req_op),
        .req_way      (req_way),
        .req_l1_way   (req_l1_way),
        .req_l1_side  (req_l1_side),
        .fill_line_q  (fill_line_q)
    );

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    l2_victim_select u_victim (
        .req_way      (req_way),
        .req_addr     (req_addr),
        .l2_tag0_rd   (l2_tag0_rd),
        .l2_tag1_rd   (l2_tag1_rd),
        .l2_tag2_rd   (l2_tag2_rd),
        .l2_tag3_rd   (l2_tag3_rd),
        .l2_data0_rd  (l2_data0_rd),
        .l2_data1_rd  (l2_data1_rd),
        .l2_data2_rd  (l2_data2_rd),
        .l2_data3_rd  (l2_data3_rd),
        .wb_line      (wb_line),
        .wb_line_addr (wb_line_addr)
    );

    l2_refill_route u_route (
        .fill          (fill),
        .req_addr      (req_addr),
        .req_op        (req_op),
        .req_way       (req_way),
        .req_l1_way    (req_l1_way),
        .req_l1_side   (req_l1_side),
        .fill_line_q   (fill_line_q),
        .l2_way_we     (l2_way_we),
        .l2_tag_wd     (l2_tag_wd),
        .l2_fill_line  (l2_fill_line),
        .l1_fill_valid (l1_fill_valid),
        .l1_fill_side  (l1_fill_side),
        .l1_block_we   (l1_block_we),
        .l1_tag_wd     (l1_tag_wd),
        .l1_index      (l1_index),
        .l1_word       (l1_word)
    );

endmodule

`default_nettype wire

//--- bench/tb_l2_miss_ctrl.sv
`default_nettype none

`include "l2_miss_defines.svh"

module tb_l2_miss_ctrl
    import l2_miss_pkg::*;
();

    localparam int ROWS         = 12;
    localparam int FIELDS       = 12;   // tokens per row of the data file
    localparam int FILL_TIMEOUT = 100;

    logic                        clk = 1'b0;
    logic                        rst_n = 1'b0;
    logic                        miss_valid = 1'b0;
    logic                        miss_dirty = 1'b0;
    access_op_t                  miss_op = OP_READ;
    logic [`L2M_ADDR_W-1:0]      miss_addr = '0;
    logic [`L2M_WAY_W-1:0]       victim_way = '0;
    logic                        l1_way = 1'b0;
    logic                        l1_side = 1'b0;
    logic [`L2M_L2_TAG_W-1:0]    l2_tag0_rd = '0;
    logic [`L2M_L2_TAG_W-1:0]    l2_tag1_rd = '0;
    logic [`L2M_L2_TAG_W-1:0]    l2_tag2_rd = '0;
    logic [`L2M_L2_TAG_W-1:0]    l2_tag3_rd = '0;
    logic [`L2M_LINE_W-1:0]      l2_data0_rd = '0;
    logic [`L2M_LINE_W-1:0]      l2_data1_rd = '0;
    logic [`L2M_LINE_W-1:0]      l2_data2_rd = '0;
    logic [`L2M_LINE_W-1:0]      l2_data3_rd = '0;
    logic                        mem_done_r = 1'b0;
    logic                        mem_done_w = 1'b0;
    logic [`L2M_LINE_W-1:0]      mem_rdata = '0;
    logic                        busy;
    logic                        mem_re;
    logic                        mem_we;
    logic [`L2M_LINE_ADDR_W-1:0] mem_addr;
    logic [`L2M_LINE_W-1:0]      mem_wdata;
    logic [`L2M_WAYS-1:0]        l2_way_we;
    logic [`L2M_LINE_W-1:0]      l2_fill_line;
    logic [`L2M_L2_TAG_W-1:0]    l2_tag_wd;
    logic                        l1_fill_valid;
    logic                        l1_fill_side;
    logic [1:0]                  l1_block_we;
    logic [`L2M_L1_TAG_W-1:0]    l1_tag_wd;
    logic [`L2M_L1_INDEX_W-1:0]  l1_index;
    logic [`L2M_WORD_W-1:0]      l1_word;

    logic [31:0] vec [0:ROWS*FIELDS-1];
    integer      seed = 32'he381;
    int          errors = 0;
    int          tests = 0;
    int          cur_row = -1;
    bit          timed_out = 1'b0;

    // memory model bookkeeping
    int                          mem_wait = 0;
    int                          mem_seq = 0;
    int                          rd_cnt = 0;
    int                          wr_cnt = 0;
    int                          rd_seq = 0;
    int                          wr_seq = 0;
    logic [`L2M_LINE_ADDR_W-1:0] rd_addr_seen = '0;
    logic [`L2M_LINE_ADDR_W-1:0] wr_addr_seen = '0;
    logic [`L2M_LINE_W-1:0]      wr_data_seen = '0;

    l2_miss_ctrl u_dut (.*);

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // line content rules
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [`L2M_LINE_W-1:0] victim_line(input logic [27:0] addr,
                                                           input logic [1:0] way);
        logic [`L2M_LINE_W-1:0] line;
        for (int k = 0; k < 16; k++) begin
            line[k*32 +: 32] = (32'(way) << 28) ^ {4'h0, addr} ^ 32'(k);
        end
        return line;
    endfunction

    function automatic logic [`L2M_LINE_W-1:0] memory_line(input logic [25:0] line_addr);
        logic [`L2M_LINE_W-1:0] line;
        for (int k = 0; k < 16; k++) begin
            line[k*32 +: 32] = ~({6'h0, line_addr} ^ 32'(k));
        end
        return line;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // main memory with a random latency per request
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        mem_done_r <= 1'b0;
        mem_done_w <= 1'b0;
        if (!(mem_re || mem_we) || mem_done_r || mem_done_w) begin
            mem_wait <= 0;              // idle, or the done cycle itself
        end else if (mem_wait == 0) begin
            mem_wait <= 1 + ($unsigned($random(seed)) % 8);
        end else if (mem_wait == 1) begin
            mem_wait   <= 0;
            mem_seq    <= mem_seq + 1;
            mem_done_r <= mem_re;
            mem_done_w <= mem_we;
            if (mem_re) begin
                mem_rdata    <= memory_line(mem_addr);
                rd_addr_seen <= mem_addr;
                rd_seq       <= mem_seq;
                rd_cnt       <= rd_cnt + 1;
            end else begin
                wr_addr_seen <= mem_addr;
                wr_data_seen <= mem_wdata;
                wr_seq       <= mem_seq;
                wr_cnt       <= wr_cnt + 1;
            end
        end else begin
            mem_wait <= mem_wait - 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail %0t: row %0d %s", $time, cur_row, msg);
    endtask

    task automatic run_miss(input int row);
        int                     b;
        int                     err0;
        int                     rd0;
        int                     wr0;
        int                     waited;
        logic [27:0]            addr;
        logic [1:0]             way;
        logic                   dirty;
        logic                   is_read;
        logic [25:0]            exp_wb;
        logic [25:0]            exp_rd;
        logic [`L2M_LINE_W-1:0] exp_line;
        b        = row * FIELDS;
        cur_row  = row;
        addr     = vec[b][27:0];
        way      = vec[b+1][1:0];
        is_read  = (vec[b+4][0] == 1'b0);
        dirty    = vec[b+5][0];
        exp_wb   = vec[b+10][25:0];
        exp_rd   = vec[b+11][25:0];
        exp_line = memory_line(exp_rd);
        err0     = errors;
        rd0      = rd_cnt;
        wr0      = wr_cnt;

        @(posedge clk);
        miss_valid  <= 1'b1;
        miss_dirty  <= dirty;
        miss_op     <= access_op_t'(vec[b+4][0]);
        miss_addr   <= addr;
        victim_way  <= way;
        l1_way      <= vec[b+2][0];
        l1_side     <= vec[b+3][0];
        l2_tag0_rd  <= vec[b+6][17:0];
        l2_tag1_rd  <= vec[b+7][17:0];
        l2_tag2_rd  <= vec[b+8][17:0];
        l2_tag3_rd  <= vec[b+9][17:0];
        l2_data0_rd <= victim_line(addr, 2'd0);
        l2_data1_rd <= victim_line(addr, 2'd1);
        l2_data2_rd <= victim_line(addr, 2'd2);
        l2_data3_rd <= victim_line(addr, 2'd3);
        @(posedge clk);                 // accepted on this edge
        miss_addr <= ~addr;             // second request while busy
        @(posedge clk);
        miss_valid <= 1'b0;

        waited = 0;
        @(negedge clk);
        while (l2_way_we == '0 && waited < FILL_TIMEOUT) begin
            if (busy !== 1'b1) report_mismatch("busy low before the fill");
            if (!dirty && mem_we !== 1'b0) report_mismatch("mem_we raised on a clean miss");
            waited++;
            @(negedge clk);
        end

        if (l2_way_we == '0) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout waiting for the fill pulse on row %0d", row);
        end else begin
            // fill cycle
            if (l2_way_we !== (4'b0001 << way))
                report_mismatch("l2_way_we not the victim way");
            if (l2_fill_line !== exp_line) report_mismatch("l2_fill_line wrong");
            if (l2_tag_wd !== {1'b1, addr[27:11]}) report_mismatch("l2_tag_wd wrong");
            if (l1_fill_valid !== is_read) report_mismatch("l1_fill_valid wrong for opcode");
            if (is_read) begin
                if (l1_word !== exp_line[int'(addr[1:0])*`L2M_WORD_W +: `L2M_WORD_W])
                    report_mismatch("l1_word wrong");
                if (l1_tag_wd !== {1'b1, addr[27:8]}) report_mismatch("l1_tag_wd wrong");
                if (l1_index !== addr[7:0]) report_mismatch("l1_index wrong");
                if (l1_block_we !== (vec[b+2][0] ? 2'b10 : 2'b01))
                    report_mismatch("l1_block_we wrong");
                if (l1_fill_side !== vec[b+3][0]) report_mismatch("l1_fill_side wrong");
            end

            @(negedge clk);
            if (l2_way_we !== '0 || l1_fill_valid !== 1'b0)
                report_mismatch("fill longer than one cycle");
            if (busy !== 1'b0) report_mismatch("busy still high after the fill");
            if (rd_cnt - rd0 != 1) report_mismatch("not exactly one line read");
            if (rd_addr_seen !== exp_rd) report_mismatch("read line address wrong");
            if (wr_cnt - wr0 != int'(dirty)) report_mismatch("write-back count wrong");
            if (dirty) begin
                if (wr_addr_seen !== exp_wb) report_mismatch("write-back address wrong");
                if (wr_data_seen !== victim_line(addr, way))
                    report_mismatch("write-back data wrong");
                if (wr_seq > rd_seq) report_mismatch("read issued before the write-back");
            end

            tests++;
            $display("test %0d: %s %s miss, %s", row, dirty ? "dirty" : "clean",
                     is_read ? "read" : "write", (errors == err0) ? "ok" : "errors");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        $readmemh("bench/l2_miss_input.txt", vec);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        repeat (3) @(negedge clk);      // idle outputs before any miss
        if (busy !== 1'b0 || mem_re !== 1'b0 || mem_we !== 1'b0 || l2_way_we !== '0 ||
            l1_fill_valid !== 1'b0)
            report_mismatch("outputs active after reset");
        tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "errors");

        for (int r = 0; r < ROWS && !timed_out; r++) begin
            run_miss(r);
        end

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/l2_miss_input.txt
// addr way l1_way l1_side op(0 rd,1 wr) dirty tag0 tag1 tag2 tag3 wb_line rd_line
// wb_line is the victim's write-back line address, unused on clean misses
0001234 0 0 0 0 0 20100 20200 20300 20400 002008D 000048D
89ABCDE 1 1 1 0 1 3f001 3f002 3f003 3f004 3E00537 226AF37
FFFFFFF 3 0 1 1 1 20100 20200 20300 20400 00801FF 3FFFFFF
0000000 2 1 0 0 1 20100 20200 20300 20400 0060000 0000000
1234567 0 1 1 1 1 3f001 3f002 3f003 3f004 3E00359 048D159
7654321 3 0 1 0 0 3f001 3f002 3f003 3f004 3E008C8 1D950C8
ABCDEF0 2 1 0 1 0 20100 20200 20300 20400 00601BC 2AF37BC
0F0F0F5 1 0 0 0 1 20100 20200 20300 20400 004003D 03C3C3D
5555556 3 1 1 0 1 3f001 3f002 3f003 3f004 3E00955 1555555
2468ACF 1 0 0 0 0 20100 20200 20300 20400 00400B3 091A2B3
C000802 2 1 1 1 1 3f001 3f002 3f003 3f004 3E00600 3000200
0000FFD 0 1 0 0 1 20100 20200 20300 20400 00201FF 00003FF

//--- verilog.f
+incdir+verilog
verilog/l2_miss_pkg.sv
verilog/l2_victim_select.sv
verilog/l2_refill_route.sv
verilog/l2_miss_fsm.sv
verilog/l2_miss_ctrl.sv
bench/tb_l2_miss_ctrl.sv

//--- Bender.yml
package:
  name: l2_miss_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/l2_miss_pkg.sv
      - verilog/l2_victim_select.sv
      - verilog/l2_refill_route.sv
      - verilog/l2_miss_fsm.sv
      - verilog/l2_miss_ctrl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_l2_miss_ctrl.sv
